/* rtl/itm_pkg.sv */
// itm package: trace field widths, boot address, sync interval and message types
`default_nettype none

package itm_pkg;

   // retired program counter width
   localparam int unsigned ADDR_WIDTH = 32;

   // trace time base width, wraps at the top
   localparam int unsigned TS_WIDTH = 32;

   // instruction count field of a basic-block record
   localparam int unsigned CNT_WIDTH = 8;

   // largest count a single record can carry
   // a longer sequential run is split into several records
   localparam logic [CNT_WIDTH-1:0] CNT_MAX = 8'd255;

   // first pc that is traced, anything before it is still boot code
   localparam logic [ADDR_WIDTH-1:0] BOOT_ADDR = 32'h0000_0100;

   // cycles between two time-sync events
   // must be a power of two
   localparam int unsigned SYNC_INTERVAL = 64;

   // low timestamp bits that are zero on a sync point
   localparam int unsigned SYNC_BITS = $clog2(SYNC_INTERVAL);

   // trace message kinds on the merged output stream
   typedef enum logic [0:0] {
      // basic-block record: start address, start ts, count
      MSG_BLOCK = 1'b0,
      // time sync: ts only, address and count are zero
      MSG_SYNC  = 1'b1
   } msg_type_e;

endpackage

`default_nettype wire

/* rtl/trace_block_if.sv */
// trace block interface: one compressed basic-block record per valid strobe
`default_nettype none

interface trace_block_if;
   import itm_pkg::*;

   // one-cycle strobe, fields below only meaningful while high
   logic                  valid;
   // pc of the first instruction in the block
   logic [ADDR_WIDTH-1:0] start_addr;
   // ts sampled with that first instruction
   logic [TS_WIDTH-1:0]   start_ts;
   // number of retired instructions in the block, never zero
   logic [CNT_WIDTH-1:0]  instr_cnt;

   // compressor side
   modport src (output valid, start_addr, start_ts, instr_cnt);

   // arbiter side
   modport dst (input valid, start_addr, start_ts, instr_cnt);

endinterface

`default_nettype wire

/* rtl/itm_timestamp.sv */
// itm timestamp unit: free-running trace time base with periodic sync strobe
`default_nettype none

module itm_timestamp (
   input  logic                          clk,
   input  logic                          rst,
   output logic [itm_pkg::TS_WIDTH-1:0]  ts,
   output logic                          sync
);
   import itm_pkg::*;

   // value ts takes on the next edge
   logic [TS_WIDTH-1:0] ts_next;
   // next value sits on a nonzero multiple of the interval
   logic                sync_next;

   assign ts_next   = ts + 1'b1;
   assign sync_next = (ts_next[SYNC_BITS-1:0] == '0) && (ts_next != '0);

   // time base, 0 in the first cycle out of reset
   always_ff @(posedge clk) begin
      if (rst) begin
         ts <= '0;
      end else begin
         ts <= ts_next;
      end
   end

   // sync registered alongside ts so both line up in the same cycle
   // no sync on wrap to zero
   always_ff @(posedge clk) begin
      if (rst) begin
         sync <= 1'b0;
      end else begin
         sync <= sync_next;
      end
   end

   // sync is a single-cycle event
   a_sync_single: assert property (@(posedge clk) disable iff (rst)
      sync |=> !sync);

endmodule

`default_nettype wire

/* rtl/itm_trace_compression.sv */
// itm trace compression: turns the retired-pc stream into basic-block records
`default_nettype none

module itm_trace_compression (
   input  logic                            clk,
   input  logic                            rst,
   input  logic [itm_pkg::ADDR_WIDTH-1:0]  pc,
   input  logic                            pc_valid,
   input  logic [itm_pkg::TS_WIDTH-1:0]    ts,
   trace_block_if.src                      blk
);
   import itm_pkg::*;

   // pc of the last accepted instruction
   logic [ADDR_WIDTH-1:0] prev_pc;
   // open block: start address, start ts, running count
   logic [ADDR_WIDTH-1:0] stream_sa;
   logic [TS_WIDTH-1:0]   stream_ts;
   logic [CNT_WIDTH-1:0]  instr_cnt;
   // set once BOOT_ADDR has retired
   logic                  boot_found;
   // strobe passes boot gating
   logic                  accept;
   // accepted pc continues the open block
   logic                  seq;
   // accepted pc closes the open block and starts another
   logic                  split;

   // zero pc is never traced, boot code before BOOT_ADDR neither
   assign accept = pc_valid && (pc != '0) && (boot_found || (pc == BOOT_ADDR));

   // pc+4 or a repeated pc (stall, self-loop) counts as sequential
   // prev_pc only valid once the first block is open
   assign seq = boot_found && ((pc == prev_pc + 32'd4) || (pc == prev_pc));

   // jump, or the count field is full
   assign split = !seq || (instr_cnt == CNT_MAX);

   // control: counter, boot flag, output strobe
   always_ff @(posedge clk) begin
      if (rst) begin
         boot_found <= 1'b0;
         instr_cnt  <= '0;
         blk.valid  <= 1'b0;
      end else begin
         blk.valid <= 1'b0;
         if (accept) begin
            boot_found <= 1'b1;
            if (split) begin
               // boot strobe only opens a block, nothing to emit yet
               blk.valid <= boot_found;
               instr_cnt <= CNT_WIDTH'(1);
            end else begin
               instr_cnt <= instr_cnt + 1'b1;
            end
         end
      end
   end

   // payload: open block fields and the record handed downstream
   always_ff @(posedge clk) begin
      if (accept) begin
         prev_pc <= pc;
         if (split) begin
            // close the running block
            blk.start_addr <= stream_sa;
            blk.start_ts   <= stream_ts;
            blk.instr_cnt  <= instr_cnt;
            // new block begins at this pc with its ts
            stream_sa <= pc;
            stream_ts <= ts;
         end
      end
   end

   // a record always covers at least one instruction
   a_cnt_nonzero: assert property (@(posedge clk) disable iff (rst)
      blk.valid |-> (blk.instr_cnt != '0));

endmodule

`default_nettype wire

/* rtl/itm_msg_arbiter.sv */
// itm message arbiter merging block records and sync events into one typed stream
`default_nettype none

module itm_msg_arbiter (
   input  logic                            clk,
   input  logic                            rst,
   trace_block_if.dst                      blk,
   input  logic [itm_pkg::TS_WIDTH-1:0]    ts,
   input  logic                            sync,
   output logic                            msg_valid,
   output itm_pkg::msg_type_e              msg_type,
   output logic [itm_pkg::ADDR_WIDTH-1:0]  msg_addr,
   output logic [itm_pkg::TS_WIDTH-1:0]    msg_ts,
   output logic [itm_pkg::CNT_WIDTH-1:0]   msg_cnt
);
   import itm_pkg::*;

   // one sync waiting behind a block record
   logic                sync_pend;
   // ts captured with the latest sync
   logic [TS_WIDTH-1:0] pend_ts;

   // output strobe and pending flag
   always_ff @(posedge clk) begin
      if (rst) begin
         msg_valid <= 1'b0;
         sync_pend <= 1'b0;
      end else begin
         msg_valid <= blk.valid || sync || sync_pend;
         if (blk.valid) begin
            // block wins the slot and any sync waits
            sync_pend <= sync_pend || sync;
         end else begin
            // free slot lets a fresh or pending sync out
            sync_pend <= 1'b0;
         end
      end
   end

   // newer sync overwrites an older pending one
   always_ff @(posedge clk) begin
      if (sync) begin
         pend_ts <= ts;
      end
   end

   // message payload with block record priority
   always_ff @(posedge clk) begin
      if (blk.valid) begin
         msg_type <= MSG_BLOCK;
         msg_addr <= blk.start_addr;
         msg_ts   <= blk.start_ts;
         msg_cnt  <= blk.instr_cnt;
      end else begin
         msg_type <= MSG_SYNC;
         msg_addr <= '0;
         msg_cnt  <= '0;
         // live sync is newer than anything pending
         if (sync) begin
            msg_ts <= ts;
         end else begin
            msg_ts <= pend_ts;
         end
      end
   end

   // sync messages carry no count
   a_sync_cnt_zero: assert property (@(posedge clk) disable iff (rst)
      (msg_valid && (msg_type == MSG_SYNC)) |-> (msg_cnt == '0));

endmodule

`default_nettype wire

/* rtl/itm_top.sv */
// itm top: timestamp unit, trace compressor and message arbiter on plain ports
`default_nettype none

module itm_top (
   input  logic                            clk,
   input  logic                            rst,
   input  logic [itm_pkg::ADDR_WIDTH-1:0]  pc,
   input  logic                            pc_valid,
   output logic                            msg_valid,
   output itm_pkg::msg_type_e              msg_type,
   output logic [itm_pkg::ADDR_WIDTH-1:0]  msg_addr,
   output logic [itm_pkg::TS_WIDTH-1:0]    msg_ts,
   output logic [itm_pkg::CNT_WIDTH-1:0]   msg_cnt
);

   // shared time base
   logic [itm_pkg::TS_WIDTH-1:0] ts;
   // periodic time-sync event
   logic                         sync;

   // compressor to arbiter record path
   trace_block_if blk_if ();

   itm_timestamp itm_timestamp_i (
      .clk  (clk),
      .rst  (rst),
      .ts   (ts),
      .sync (sync)
   );

   // records carry the ts of their first instruction
   itm_trace_compression itm_trace_compression_i (
      .clk      (clk),
      .rst      (rst),
      .pc       (pc),
      .pc_valid (pc_valid),
      .ts       (ts),
      .blk      (blk_if.src)
   );

   itm_msg_arbiter itm_msg_arbiter_i (
      .clk       (clk),
      .rst       (rst),
      .blk       (blk_if.dst),
      .ts        (ts),
      .sync      (sync),
      .msg_valid (msg_valid),
      .msg_type  (msg_type),
      .msg_addr  (msg_addr),
      .msg_ts    (msg_ts),
      .msg_cnt   (msg_cnt)
   );

endmodule

`default_nettype wire

/* tb/itm_tb.sv */
// itm testbench driving a table of retired pcs against expected block and sync messages
`default_nettype none

module itm_tb;
   import itm_pkg::*;

   localparam int unsigned CLK_PERIOD = 8;
   localparam int unsigned DRIVE_DLY  = 1;
   localparam int unsigned TABLE_LEN  = 400;
   // sync point that the jump burst lands on
   localparam int unsigned COLLIDE    = 5 * SYNC_INTERVAL;

   logic                  clk;
   logic                  rst;
   logic [ADDR_WIDTH-1:0] pc;
   logic                  pc_valid;
   logic                  msg_valid;
   msg_type_e             msg_type;
   logic [ADDR_WIDTH-1:0] msg_addr;
   logic [TS_WIDTH-1:0]   msg_ts;
   logic [CNT_WIDTH-1:0]  msg_cnt;

   // stimulus table with one entry per cycle after reset release
   logic [ADDR_WIDTH-1:0] stim_pc [TABLE_LEN];
   logic                  stim_vld [TABLE_LEN];
   int                    build_idx;
   // expected blocks with start address, count, first table index and test id
   logic [ADDR_WIDTH-1:0] exp_addr [$];
   int                    exp_cnt [$];
   int                    exp_idx [$];
   int                    exp_test [$];
   int                    n_block;
   int                    n_sync;
   int                    test_err [1:5];
   string                 test_name [1:5];
   int                    total_err;
   logic [ADDR_WIDTH-1:0] jpc;

   itm_top itm_top_i (
      .clk       (clk),
      .rst       (rst),
      .pc        (pc),
      .pc_valid  (pc_valid),
      .msg_valid (msg_valid),
      .msg_type  (msg_type),
      .msg_addr  (msg_addr),
      .msg_ts    (msg_ts),
      .msg_cnt   (msg_cnt)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic put_stim(input logic [ADDR_WIDTH-1:0] p, input logic v);
      stim_pc[build_idx]  = p;
      stim_vld[build_idx] = v;
      build_idx++;
   endtask

   task automatic add_block(input logic [ADDR_WIDTH-1:0] a, input int c, input int i,
                            input int t);
      exp_addr.push_back(a);
      exp_cnt.push_back(c);
      exp_idx.push_back(i);
      exp_test.push_back(t);
   endtask

   // entry 0 is sampled in the first cycle out of reset where ts is 0
   function automatic logic [TS_WIDTH-1:0] idx_to_ts(input int idx);
      return TS_WIDTH'(idx);
   endfunction

   task automatic report_mismatch(input int t, input string sig, input logic [31:0] got,
                                  input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAILED t=%0t %s got %h expected %h", $time, sig, got, exp);
         test_err[t]++;
      end
   endtask

   task automatic check_block(input int t, input logic [ADDR_WIDTH-1:0] got_addr,
                              input logic [TS_WIDTH-1:0] got_ts,
                              input logic [CNT_WIDTH-1:0] got_cnt,
                              input logic [ADDR_WIDTH-1:0] want_addr,
                              input logic [TS_WIDTH-1:0] want_ts,
                              input logic [CNT_WIDTH-1:0] want_cnt);
      report_mismatch(t, "msg_addr", got_addr, want_addr);
      report_mismatch(t, "msg_ts", got_ts, want_ts);
      report_mismatch(t, "msg_cnt", got_cnt, want_cnt);
   endtask

   // sync carries only a ts with zero address and count
   task automatic check_sync(input int t, input msg_type_e got_type,
                             input logic [TS_WIDTH-1:0] got_ts,
                             input logic [TS_WIDTH-1:0] want_ts,
                             input logic [ADDR_WIDTH-1:0] got_addr,
                             input logic [CNT_WIDTH-1:0] got_cnt);
      report_mismatch(t, "msg_type", got_type, MSG_SYNC);
      report_mismatch(t, "msg_ts", got_ts, want_ts);
      report_mismatch(t, "msg_addr", got_addr, '0);
      report_mismatch(t, "msg_cnt", got_cnt, '0);
   endtask

   // outputs sampled in the low phase after they settle
   always @(negedge clk) begin
      if (!rst && msg_valid === 1'b1) begin
         // a record never has a zero count so either marker means a sync
         if ((msg_type == MSG_SYNC) || (msg_cnt == '0)) begin
            // k-th sync lands on the k-th nonzero multiple of the interval
            check_sync((SYNC_INTERVAL * (n_sync + 1) == COLLIDE) ? 5 : 4, msg_type, msg_ts,
                       TS_WIDTH'(SYNC_INTERVAL * (n_sync + 1)), msg_addr, msg_cnt);
            n_sync++;
         end else if (n_block < exp_addr.size()) begin
            check_block(exp_test[n_block], msg_addr, msg_ts, msg_cnt, exp_addr[n_block],
                        idx_to_ts(exp_idx[n_block]), CNT_WIDTH'(exp_cnt[n_block]));
            n_block++;
         end else begin
            $display("t=%0t block message at %h arrived after all expected blocks",
                     $time, msg_addr);
            test_err[2]++;
         end
      end
   end

   // watchdog over the table length plus margin
   initial begin
      #((TABLE_LEN + 200) * CLK_PERIOD);
      $display("timeout: run did not end within %0d cycles", TABLE_LEN + 200);
      $display("Test failed");
      $finish;
   end

   initial begin
      rst      = 1'b1;
      pc       = '0;
      pc_valid = 1'b0;
      n_block  = 0;
      n_sync   = 0;
      total_err = 0;
      build_idx = 0;
      test_name[1] = "boot gating";
      test_name[2] = "block compression";
      test_name[3] = "overflow split";
      test_name[4] = "time sync";
      test_name[5] = "sync collision";
      for (int t = 1; t <= 5; t++) begin
         test_err[t] = 0;
      end
      for (int i = 0; i < TABLE_LEN; i++) begin
         stim_pc[i]  = '0;
         stim_vld[i] = 1'b0;
      end
      // zero pc, pre-boot code, an idle slot
      put_stim(32'h0, 1'b1);
      put_stim(32'h80, 1'b1);
      put_stim(32'h84, 1'b1);
      put_stim(32'h88, 1'b0);
      put_stim(32'h0, 1'b1);
      // 300 sequential from boot that split at CNT_MAX
      add_block(BOOT_ADDR, CNT_MAX, build_idx, 1);
      for (int j = 0; j < 300; j++) begin
         // zero pc after boot is still ignored
         if (j == 100) begin
            put_stim(32'h0, 1'b1);
         end
         if (j == CNT_MAX) begin
            add_block(BOOT_ADDR + 4 * CNT_MAX, 300 - CNT_MAX, build_idx, 3);
         end
         put_stim(BOOT_ADDR + 4 * j, 1'b1);
      end
      // +4 run with a repeated pc and then two jumps back to back
      add_block(32'h2000, 5, build_idx, 2);
      put_stim(32'h2000, 1'b1);
      put_stim(32'h2004, 1'b1);
      put_stim(32'h2004, 1'b1);
      put_stim(32'h2008, 1'b1);
      put_stim(32'h200c, 1'b1);
      add_block(32'h3000, 1, build_idx, 2);
      put_stim(32'h3000, 1'b1);
      // jump every cycle across the sync point
      jpc = 32'h4000;
      put_stim(jpc, 1'b1);
      while (build_idx <= COLLIDE + 10) begin
         add_block(jpc, 1, build_idx - 1, 5);
         jpc = jpc + 32'h100;
         put_stim(jpc, 1'b1);
      end

      repeat (8) @(posedge clk);
      #DRIVE_DLY;
      rst = 1'b0;
      for (int i = 0; i < TABLE_LEN; i++) begin
         pc       = stim_pc[i];
         pc_valid = stim_vld[i];
         @(posedge clk);
         #DRIVE_DLY;
      end
      pc_valid = 1'b0;
      repeat (4) @(posedge clk);
      @(negedge clk);

      if (n_block != exp_addr.size()) begin
         $display("only %0d of %0d block messages arrived", n_block, exp_addr.size());
         test_err[exp_test[n_block]]++;
      end
      if (n_sync != (TABLE_LEN - 1) / SYNC_INTERVAL) begin
         $display("saw %0d sync messages, wanted %0d", n_sync,
                  (TABLE_LEN - 1) / SYNC_INTERVAL);
         test_err[4]++;
      end
      for (int t = 1; t <= 5; t++) begin
         $display("test %0d %s: %s, %0d errors", t, test_name[t],
                  (test_err[t] == 0) ? "ok" : "FAILED", test_err[t]);
         total_err += test_err[t];
      end
      $display("%0d blocks, %0d syncs checked, %0d errors", n_block, n_sync, total_err);
      if (total_err == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* list.f */
rtl/itm_pkg.sv
rtl/trace_block_if.sv
rtl/itm_timestamp.sv
rtl/itm_trace_compression.sv
rtl/itm_msg_arbiter.sv
rtl/itm_top.sv
tb/itm_tb.sv

/* Bender.yml */
package:
  name: itm

dependencies: {}

sources:
  - rtl/itm_pkg.sv
  - rtl/trace_block_if.sv
  - rtl/itm_timestamp.sv
  - rtl/itm_trace_compression.sv
  - rtl/itm_msg_arbiter.sv
  - rtl/itm_top.sv
  - target: test
    files:
      - tb/itm_tb.sv
